// File: source/hdr_mem_pkg.sv
package hdr_mem_pkg;

	typedef logic [127:0] ram_word_t;	// Eight pixels, lane 0 in the low bits.
	typedef logic [24:0] ram_addr_t;
	typedef logic [2:0] frame_slot_t;	// Valid codes 0 to 5.
	typedef logic [1:0] exposure_t;	// 0 low, 1 mid, 2 high.

	function automatic exposure_t slot_exposure(frame_slot_t slot);
		return exposure_t'(slot % 3);
	endfunction

	function automatic logic slot_bank(frame_slot_t slot);
		return (slot >= 3'd3);
	endfunction

	// Word address of one exposure in a bank.
	function automatic ram_addr_t slot_address(logic bank, exposure_t exposure,
			int unsigned frame_words, ram_addr_t index);
		int unsigned base;
		base = (bank * 3 + exposure) * frame_words;
		return ram_addr_t'(base) + index;
	endfunction

endpackage

// File: source/hdr_pixel_pkg.sv
package hdr_pixel_pkg;

	// Camera pixel layout.
	// red   : bits 7 to 3
	// green : bits 2 to 0, then bits 15 to 13
	// blue  : bits 12 to 8
	typedef logic [15:0] pixel_t;

	typedef logic [2:0] lane_t;	// Lane 0 is word bits 15 to 0.
	typedef logic [7:0] hdr_channel_t;

	typedef enum logic [2:0] {
		IDLE,
		READ_A,
		WAIT_A,
		READ_B,
		WAIT_B,
		EMIT
	} seq_state_t;

	localparam int PIXEL_BITS = 16;

endpackage

// File: source/exposure_pixel_if.sv
`timescale 1ns/100ps

interface exposure_pixel_if;
	import hdr_pixel_pkg::*;

	logic valid;
	pixel_t px_low;
	pixel_t px_mid;
	pixel_t px_high;

	modport source (
		output valid,
		output px_low,
		output px_mid,
		output px_high
	);

	modport sink (
		input valid,
		input px_low,
		input px_mid,
		input px_high
	);
endinterface

// File: source/hdr_read_sequencer.sv
`timescale 1ns/100ps

module hdr_read_sequencer #(
	parameter int unsigned FRAME_WORDS = 153600
) (
	input logic clk,
	input logic rst_n,
	input logic hdr_en,
	input logic frame_done,
	input logic camera_wr_req,
	input logic rd_valid,
	input logic ram_busy,
	input hdr_mem_pkg::frame_slot_t last_frame,
	input logic lane_last,
	output logic rd_req,
	output hdr_mem_pkg::ram_addr_t rd_address,
	output logic load,
	output hdr_mem_pkg::exposure_t load_exposure,
	output logic lane_run,
	output logic busy
);
	import hdr_mem_pkg::*;
	import hdr_pixel_pkg::*;

	seq_state_t state;
	frame_slot_t slot;	// Latched on frame_done.
	ram_addr_t word_idx;
	exposure_t cam_exp;
	exposure_t exp_a;
	exposure_t exp_b;
	exposure_t rd_exp;
	logic accept;
	logic issue;

	assign cam_exp = slot_exposure(slot);
	assign exp_a = (cam_exp == 2'd0) ? 2'd1 : 2'd0;	// Lower of the other two.
	assign exp_b = (cam_exp == 2'd2) ? 2'd1 : 2'd2;
	assign rd_exp = (state == READ_B) ? exp_b : exp_a;

	assign accept = (state == IDLE) && hdr_en && camera_wr_req;
	assign issue = ((state == READ_A) || (state == READ_B)) && hdr_en && !ram_busy;

	assign rd_req = issue;	// Never while the RAM is busy.
	assign rd_address = slot_address(slot_bank(slot), rd_exp, FRAME_WORDS, word_idx);

	// Read returns only. The buffer takes camera words itself into load_exposure.
	assign load = ((state == WAIT_A) || (state == WAIT_B)) && rd_valid;

	always_comb begin
		case (state)
			READ_A, WAIT_A: load_exposure = exp_a;
			READ_B, WAIT_B: load_exposure = exp_b;
			default: load_exposure = cam_exp;	// Camera word slot.
		endcase
	end

	assign lane_run = (state == EMIT);
	assign busy = (state != IDLE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot <= '0;
			word_idx <= '0;
		end else if (frame_done) begin
			slot <= last_frame;
			word_idx <= '0;
		end else if (lane_run && lane_last) begin
			word_idx <= word_idx + 1'b1;	// Next camera word.
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (accept)
						state <= READ_A;
				end
				READ_A: begin
					if (issue)
						state <= WAIT_A;
				end
				WAIT_A: begin
					if (rd_valid)
						state <= READ_B;
				end
				READ_B: begin
					if (issue)
						state <= WAIT_B;
				end
				WAIT_B: begin
					if (rd_valid)
						state <= EMIT;
				end
				EMIT: begin
					if (lane_last)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: source/lane_counter.sv
`timescale 1ns/100ps

module lane_counter (
	input logic clk,
	input logic rst_n,
	input logic lane_run,
	output hdr_pixel_pkg::lane_t lane,
	output logic lane_last
);

	always_ff @(posedge clk) begin
		if (!rst_n)
			lane <= '0;
		else if (lane_run)
			lane <= lane + 1'b1;	// Wraps from 7 to 0.
		else
			lane <= '0;
	end

	assign lane_last = (lane == 3'd7);

endmodule

// File: source/exposure_buffer.sv
`timescale 1ns/100ps

module exposure_buffer (
	input logic clk,
	input logic rst_n,
	input logic load,
	input hdr_mem_pkg::exposure_t load_exposure,
	input logic camera_wr_req,
	input hdr_mem_pkg::ram_word_t camera_data,
	input hdr_mem_pkg::ram_word_t rd_data,
	input logic lane_run,
	input hdr_pixel_pkg::lane_t lane,
	exposure_pixel_if.source pix
);
	import hdr_mem_pkg::*;
	import hdr_pixel_pkg::*;

	ram_word_t words [3];	// Indexed by exposure.
	logic [6:0] lane_lsb;

	assign lane_lsb = {lane, 4'b0000};

	// A read return wins over a camera word in the same cycle.
	// Outside EMIT, load_exposure points at the camera slot or at a read
	// still pending, which its return then overwrites.
	always_ff @(posedge clk) begin
		if (load)
			words[load_exposure] <= rd_data;
		else if (camera_wr_req && !lane_run)
			words[load_exposure] <= camera_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pix.valid <= 1'b0;
		else
			pix.valid <= lane_run;
	end

	always_ff @(posedge clk) begin
		if (lane_run) begin
			pix.px_low <= words[0][lane_lsb +: PIXEL_BITS];
			pix.px_mid <= words[1][lane_lsb +: PIXEL_BITS];
			pix.px_high <= words[2][lane_lsb +: PIXEL_BITS];
		end
	end

endmodule

// File: source/exposure_merge.sv
`timescale 1ns/100ps

module exposure_merge (
	input logic clk,
	input logic rst_n,
	exposure_pixel_if.sink pix,
	output logic pixel_valid,
	output hdr_pixel_pkg::hdr_channel_t hdr_red,
	output hdr_pixel_pkg::hdr_channel_t hdr_green,
	output hdr_pixel_pkg::hdr_channel_t hdr_blue
);
	import hdr_pixel_pkg::*;

	function automatic logic [4:0] red_of(pixel_t p);
		return p[7:3];
	endfunction

	function automatic logic [5:0] green_of(pixel_t p);
		return {p[2:0], p[15:13]};	// Split field.
	endfunction

	function automatic logic [4:0] blue_of(pixel_t p);
		return p[12:8];
	endfunction

	logic s1_valid;
	logic [4:0] red_s1 [3];	// Low, mid, high.
	logic [5:0] green_s1 [3];
	logic [4:0] blue_s1 [3];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			pixel_valid <= 1'b0;
		end else begin
			s1_valid <= pix.valid;
			pixel_valid <= s1_valid;
		end
	end

	// Stage 1, unpack.
	always_ff @(posedge clk) begin
		red_s1[0] <= red_of(pix.px_low);
		red_s1[1] <= red_of(pix.px_mid);
		red_s1[2] <= red_of(pix.px_high);
		green_s1[0] <= green_of(pix.px_low);
		green_s1[1] <= green_of(pix.px_mid);
		green_s1[2] <= green_of(pix.px_high);
		blue_s1[0] <= blue_of(pix.px_low);
		blue_s1[1] <= blue_of(pix.px_mid);
		blue_s1[2] <= blue_of(pix.px_high);
	end

	// Stage 2, sum. Largest green sum is 189, so no overflow.
	always_ff @(posedge clk) begin
		hdr_red <= hdr_channel_t'(red_s1[0]) + hdr_channel_t'(red_s1[1])
			+ hdr_channel_t'(red_s1[2]);
		hdr_green <= hdr_channel_t'(green_s1[0]) + hdr_channel_t'(green_s1[1])
			+ hdr_channel_t'(green_s1[2]);
		hdr_blue <= hdr_channel_t'(blue_s1[0]) + hdr_channel_t'(blue_s1[1])
			+ hdr_channel_t'(blue_s1[2]);
	end

endmodule

// File: source/hdr_image_top.sv
`timescale 1ns/100ps

module hdr_image_top #(
	parameter int unsigned FRAME_WORDS = 153600
) (
	input logic clk,
	input logic rst_n,
	input logic hdr_en,
	input logic frame_done,
	input hdr_mem_pkg::frame_slot_t last_frame,
	input logic camera_wr_req,
	input hdr_mem_pkg::ram_word_t camera_data,
	input hdr_mem_pkg::ram_word_t rd_data,
	input logic rd_valid,
	input logic ram_busy,
	output logic rd_req,
	output hdr_mem_pkg::ram_addr_t rd_address,
	output logic busy,
	output logic pixel_valid,
	output hdr_pixel_pkg::hdr_channel_t hdr_red,
	output hdr_pixel_pkg::hdr_channel_t hdr_green,
	output hdr_pixel_pkg::hdr_channel_t hdr_blue
);
	import hdr_mem_pkg::*;
	import hdr_pixel_pkg::*;

	logic load;
	exposure_t load_exposure;
	logic lane_run;
	lane_t lane;
	logic lane_last;

	exposure_pixel_if pix_if ();

	hdr_read_sequencer #(
		.FRAME_WORDS (FRAME_WORDS)
	) u_sequencer (
		.clk (clk),
		.rst_n (rst_n),
		.hdr_en (hdr_en),
		.frame_done (frame_done),
		.camera_wr_req (camera_wr_req),
		.rd_valid (rd_valid),
		.ram_busy (ram_busy),
		.last_frame (last_frame),
		.lane_last (lane_last),
		.rd_req (rd_req),
		.rd_address (rd_address),
		.load (load),
		.load_exposure (load_exposure),
		.lane_run (lane_run),
		.busy (busy)
	);

	lane_counter u_lane_counter (
		.clk (clk),
		.rst_n (rst_n),
		.lane_run (lane_run),
		.lane (lane),
		.lane_last (lane_last)
	);

	exposure_buffer u_buffer (
		.clk (clk),
		.rst_n (rst_n),
		.load (load),
		.load_exposure (load_exposure),
		.camera_wr_req (camera_wr_req),
		.camera_data (camera_data),
		.rd_data (rd_data),
		.lane_run (lane_run),
		.lane (lane),
		.pix (pix_if.source)
	);

	exposure_merge u_merge (
		.clk (clk),
		.rst_n (rst_n),
		.pix (pix_if.sink),
		.pixel_valid (pixel_valid),
		.hdr_red (hdr_red),
		.hdr_green (hdr_green),
		.hdr_blue (hdr_blue)
	);

endmodule

// File: sim/hdr_image_properties.sv
`timescale 1ns/100ps

module hdr_image_properties (
	input logic clk,
	input logic rst_n,
	input logic hdr_en,
	input logic ram_busy,
	input logic rd_req,
	input logic busy,
	input logic pixel_valid
);

	logic [3:0] run_len;	// Length of the current pixel_valid run.
	int unsigned failures = 0;	// Failed assertions so far.

	always_ff @(posedge clk) begin
		if (!rst_n)
			run_len <= '0;
		else if (pixel_valid)
			run_len <= run_len + 1'b1;
		else
			run_len <= '0;
	end

	no_req_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
		ram_busy |-> !rd_req)
	else begin
		failures++;
		$error("rd_req while ram_busy is high");
	end

	quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (!rd_req && !busy && !pixel_valid))
	else begin
		failures++;
		$error("Outputs not low after reset");
	end

	run_not_too_long: assert property (@(posedge clk) disable iff (!rst_n)
		pixel_valid |-> (run_len < 4'd8))
	else begin
		failures++;
		$error("Pixel run longer than eight");
	end

	run_complete: assert property (@(posedge clk) disable iff (!rst_n)
		(!pixel_valid && run_len != 4'd0) |-> (run_len == 4'd8))
	else begin
		failures++;
		$error("Pixel run shorter than eight");
	end

	no_req_when_disabled: assert property (@(posedge clk) disable iff (!rst_n)
		!hdr_en |-> !rd_req)
	else begin
		failures++;
		$error("rd_req while hdr_en is low");
	end

endmodule

bind hdr_image_top hdr_image_properties u_properties (
	.clk (clk),
	.rst_n (rst_n),
	.hdr_en (hdr_en),
	.ram_busy (ram_busy),
	.rd_req (rd_req),
	.busy (busy),
	.pixel_valid (pixel_valid)
);

// File: sim/hdr_image_tb.sv
`timescale 1ns/100ps

module hdr_image_tb;

	localparam int FRAME_WORDS = 2;
	localparam int TIMEOUT = 200;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic hdr_en = 1'b0;
	logic frame_done = 1'b0;
	logic [2:0] last_frame = '0;
	logic camera_wr_req = 1'b0;
	logic [127:0] camera_data = '0;
	logic [127:0] rd_data = '0;
	logic rd_valid = 1'b0;
	logic ram_busy = 1'b0;
	logic rd_req;
	logic [24:0] rd_address;
	logic busy;
	logic pixel_valid;
	logic [7:0] hdr_red;
	logic [7:0] hdr_green;
	logic [7:0] hdr_blue;

	logic [127:0] mem [int];	// RAM model contents.
	int rd_log [$];	// Addresses of issued reads.
	logic force_busy = 1'b0;
	logic [16:0] lfsr = 17'd78606;
	logic pending = 1'b0;
	int delay;
	int delay_left = 0;
	int pend_addr;
	int cur_slot = 0;
	int cur_idx = 0;

	hdr_image_top #(
		.FRAME_WORDS (FRAME_WORDS)
	) uut (
		.clk (clk),
		.rst_n (rst_n),
		.hdr_en (hdr_en),
		.frame_done (frame_done),
		.last_frame (last_frame),
		.camera_wr_req (camera_wr_req),
		.camera_data (camera_data),
		.rd_data (rd_data),
		.rd_valid (rd_valid),
		.ram_busy (ram_busy),
		.rd_req (rd_req),
		.rd_address (rd_address),
		.busy (busy),
		.pixel_valid (pixel_valid),
		.hdr_red (hdr_red),
		.hdr_green (hdr_green),
		.hdr_blue (hdr_blue)
	);

	initial begin
		forever #20 clk = ~clk;
	end

	function automatic logic [16:0] lfsr_step(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};	// x^17 + x^14 + 1.
	endfunction

	function automatic logic [127:0] ram_read(input int a);
		logic [31:0] fill;
		fill = a * 32'h9E37_79B1 + 32'h0000_1357;
		if (mem.exists(a))
			return mem[a];
		return {4{fill}};
	endfunction

	// Sum of the three exposures per channel, as {red, green, blue}.
	function automatic logic [23:0] merged(input logic [15:0] a, b, c);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] bl;
		r = 8'(a[7:3]) + 8'(b[7:3]) + 8'(c[7:3]);
		g = 8'({a[2:0], a[15:13]}) + 8'({b[2:0], b[15:13]}) + 8'({c[2:0], c[15:13]});
		bl = 8'(a[12:8]) + 8'(b[12:8]) + 8'(c[12:8]);
		return {r, g, bl};
	endfunction

	task automatic fail_now();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s (got %0h, expected %0h)", $time, msg,
				actual, expected);
			fail_now();
		end
	endtask

	// RAM model with random latency and random busy.
	always @(posedge clk) begin
		if (rst_n) begin
			rd_valid <= 1'b0;
			lfsr = lfsr_step(lfsr);
			delay = lfsr[0];
			lfsr = lfsr_step(lfsr);
			ram_busy <= force_busy | (delay[0] & lfsr[0]);
			if (pending) begin
				if (delay_left == 0) begin
					rd_valid <= 1'b1;
					rd_data <= ram_read(pend_addr);
					pending = 1'b0;
				end else begin
					delay_left--;
				end
			end
			if (rd_req) begin
				if (pending) begin
					$display("Read request issued before the previous one was answered");
					fail_now();
				end
				rd_log.push_back(int'(rd_address));
				pend_addr = rd_address;
				pending = 1'b1;
				lfsr = lfsr_step(lfsr);
				delay_left = lfsr[0];
				lfsr = lfsr_step(lfsr);
				delay_left = delay_left * 2 + lfsr[0];	// 1 to 4 cycles.
			end
		end
	end

	task automatic pulse_frame_done(input int slot);
		@(posedge clk);
		frame_done <= 1'b1;
		last_frame <= 3'(slot);
		@(posedge clk);
		frame_done <= 1'b0;
		cur_slot = slot;
		cur_idx = 0;
	endtask

	// Camera word with hdr_en low must leave the DUT idle.
	task automatic ignored_word();
		@(posedge clk);
		hdr_en <= 1'b0;
		camera_wr_req <= 1'b1;
		camera_data <= {4{32'hBAD0_0BAD}};
		@(posedge clk);
		camera_wr_req <= 1'b0;
		repeat (8) begin
			@(negedge clk);
			check_equal(busy, 1'b0, "busy while disabled");
			check_equal(pixel_valid, 1'b0, "pixel while disabled");
			check_equal(rd_log.size(), 0, "read while disabled");
		end
		@(posedge clk);
		hdr_en <= 1'b1;
	endtask

	task automatic run_word(input logic [127:0] word, input int exp_sum, input bit stall);
		int bank;
		int ex;
		int addr_lo;
		int addr_hi;
		int n;
		int total;
		logic [127:0] w_lo;
		logic [127:0] w_hi;
		logic [23:0] exp_px;
		bank = cur_slot / 3;
		ex = cur_slot % 3;
		addr_lo = -1;
		addr_hi = -1;
		for (int x = 0; x < 3; x++) begin
			if (x != ex) begin
				if (addr_lo < 0)
					addr_lo = (bank * 3 + x) * FRAME_WORDS + cur_idx;
				else
					addr_hi = (bank * 3 + x) * FRAME_WORDS + cur_idx;
			end
		end
		w_lo = ram_read(addr_lo);
		w_hi = ram_read(addr_hi);
		@(posedge clk);
		camera_data <= word;
		camera_wr_req <= 1'b1;
		if (stall)
			force_busy <= 1'b1;
		@(posedge clk);
		camera_data <= ~word;	// Arrives while busy.
		@(negedge clk);
		check_equal(busy, 1'b1, "busy after accepted word");
		@(posedge clk);
		camera_wr_req <= 1'b0;
		if (stall) begin
			repeat (10) begin
				@(negedge clk);
				check_equal(rd_log.size(), 0, "read during stall");
			end
			@(posedge clk);
			force_busy <= 1'b0;
		end
		n = 0;
		@(negedge clk);
		while (!pixel_valid) begin
			n++;
			if (n > TIMEOUT) begin
				$display("Timeout waiting for the first pixel of a word");
				fail_now();
			end
			@(negedge clk);
		end
		total = 0;
		for (int lane = 0; lane < 8; lane++) begin
			check_equal(pixel_valid, 1'b1, "pixel_valid inside run");
			exp_px = merged(word[lane*16 +: 16], w_lo[lane*16 +: 16], w_hi[lane*16 +: 16]);
			check_equal({hdr_red, hdr_green, hdr_blue}, exp_px, "merged pixel");
			total += hdr_red + hdr_green + hdr_blue;
			@(negedge clk);
		end
		check_equal(pixel_valid, 1'b0, "pixel_valid after eight");
		check_equal(total, exp_sum, "pixel sum of word");
		check_equal(rd_log.size(), 2, "reads per word");
		check_equal(rd_log[0], addr_lo, "first read address");
		check_equal(rd_log[1], addr_hi, "second read address");
		rd_log.delete();
		n = 0;
		while (busy) begin
			n++;
			if (n > TIMEOUT) begin
				$display("Timeout waiting for busy to fall");
				fail_now();
			end
			@(negedge clk);
		end
		cur_idx++;
	endtask

	initial begin
		int fd;
		int code;
		int wcount;
		int slot;
		int sum;
		int addr;
		string line;
		logic [127:0] word;
		wcount = 0;
		fd = $fopen("sim/hdr_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file sim/hdr_stimulus.txt");
			fail_now();
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		hdr_en <= 1'b1;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2 || line[0] == "#")
				continue;
			case (line[0])
				"M": begin
					code = $sscanf(line, "M %h %h", addr, word);
					mem[addr] = word;
				end
				"F": begin
					code = $sscanf(line, "F %d", slot);
					pulse_frame_done(slot);
				end
				"W": begin
					code = $sscanf(line, "W %h %d", word, sum);
					if (wcount == 1)
						ignored_word();
					run_word(word, sum, wcount == 3);
					wcount++;
				end
				default: begin
					$display("Unknown line in the stimulus file: %s", line);
					fail_now();
				end
			endcase
		end
		$fclose(fd);
		check_equal(wcount, 7, "camera words in stimulus");
		repeat (4) @(posedge clk);
		if (uut.u_properties.failures == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: sim/hdr_stimulus.txt
# M <ram address hex> <ram word hex>
# F <slot 0..5>   W <camera word hex> <sum of red+green+blue over the eight pixels, decimal>
M 0 21082108210821082108210821082108
M 2 02110211021102110211021102110211
M 3 20212021202120212021202120212021
M 4 20212021202120212021202120212021
M 5 ffffffffffffffffffffffffffffffff
M 6 02110211021102110211021102110211
M 8 21082108210821082108210821082108
M a 20212021202120212021202120212021
F 0
W 00400038003000280020001800100008 236
W 02110211021102110211021102110211 1200
F 1
W 20212021202120212021202120212021 232
F 2
W 00400038003000280020001800100008 156
F 3
W 21082108210821082108210821082108 152
F 4
W 02110211021102110211021102110211 296
F 5
W 20212021202120212021202120212021 224

// File: files.f
source/hdr_mem_pkg.sv
source/hdr_pixel_pkg.sv
source/exposure_pixel_if.sv
source/hdr_read_sequencer.sv
source/lane_counter.sv
source/exposure_buffer.sv
source/exposure_merge.sv
source/hdr_image_top.sv
sim/hdr_image_properties.sv
sim/hdr_image_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal -j 0
TOP ?= hdr_image_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
